// ==== mips_core.f ====
+incdir+tests
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/stage_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_unit.sv
logic/mips_core.sv
tests/tb_mips_core.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mips_core -f mips_core.f || exit 1
out=$(./obj_dir/Vtb_mips_core)
echo "$out"
echo "$out" | grep -qx "Done: no errors" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tests/isa_model.svh ====
`ifndef isa_model_svh
`define isa_model_svh

// in-order run of imem with one delay slot per branch or jump
task automatic run_model(input int max_steps);
	logic [31:0] regs [32];
	logic [31:0] mem [64];
	logic [31:0] pc, npc, nnpc, pc4, a, b, sext, addr, wr_val;
	logic [4:0]  wr_reg;
	instr_t      ins;
	int          steps;
	for (int i = 0; i < 32; i++) begin
		regs[i] = 32'h0;
	end
	for (int i = 0; i < 64; i++) begin
		mem[i] = init_word(32'(i * 4));
	end
	pc = reset_pc;
	npc = reset_pc + 32'd4;
	steps = 0;
	while (pc != loop_pc && steps < max_steps) begin
		ins    = imem[pc[9:2]];
		a      = regs[ins.r.rs];
		b      = regs[ins.r.rt];
		sext   = {{16{ins.i.imm[15]}}, ins.i.imm};
		addr   = a + sext;
		pc4    = pc + 32'd4;
		nnpc   = npc + 32'd4;
		wr_reg = 5'd0;
		wr_val = 32'h0;
		case (ins.r.op)
			op_special: begin
				wr_reg = ins.r.rd;
				case (ins.r.funct)
					fn_addu: wr_val = a + b;
					fn_subu: wr_val = a - b;
					fn_and:  wr_val = a & b;
					fn_or:   wr_val = a | b;
					fn_xor:  wr_val = a ^ b;
					fn_slt:  wr_val = {31'h0, $signed(a) < $signed(b)};
					fn_sll:  wr_val = b << ins.r.shamt;
					fn_jr: begin
						wr_reg = 5'd0;
						nnpc   = a;
					end
					default: wr_reg = 5'd0;
				endcase
			end
			op_addiu: begin
				wr_reg = ins.i.rt;
				wr_val = a + sext;
			end
			op_ori: begin
				wr_reg = ins.i.rt;
				wr_val = a | {16'h0, ins.i.imm};
			end
			op_lui: begin
				wr_reg = ins.i.rt;
				wr_val = {ins.i.imm, 16'h0};
			end
			op_lw: begin
				wr_reg = ins.i.rt;
				wr_val = mem[addr[7:2]];
			end
			op_sw: begin
				mem[addr[7:2]] = b;
				exp_st_addr.push_back({addr[31:2], 2'b00});
				exp_st_data.push_back(b);
			end
			op_beq: begin
				if (a == b) begin
					nnpc = pc4 + {sext[29:0], 2'b00};
				end
			end
			op_bne: begin
				if (a != b) begin
					nnpc = pc4 + {sext[29:0], 2'b00};
				end
			end
			op_j: nnpc = {pc4[31:28], ins.j.index, 2'b00};
			op_jal: begin
				nnpc   = {pc4[31:28], ins.j.index, 2'b00};
				wr_reg = reg_ra;
				wr_val = pc + 32'd8;
			end
			default: ;
		endcase
		if (wr_reg != 5'd0) begin
			regs[wr_reg] = wr_val;
			exp_pc.push_back(pc);
			exp_reg.push_back(wr_reg);
			exp_val.push_back(wr_val);
		end
		pc = npc;
		npc = nnpc;
		steps++;
	end
	assert (pc == loop_pc) else begin
		other_err++;
		$display("reference run never reached the end loop");
	end
endtask

`endif

// ==== tests/tb_mips_core.sv ====
`default_nettype none

module tb_mips_core;
	import isa_pkg::*;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        inst_sram_en;
	logic [31:0] inst_sram_addr;
	logic [31:0] inst_sram_rdata = 32'h0;
	logic        data_sram_en;
	logic [3:0]  data_sram_wen;
	logic [31:0] data_sram_addr;
	logic [31:0] data_sram_wdata;
	logic [31:0] data_sram_rdata = 32'h0;
	logic [31:0] debug_wb_pc;
	logic        debug_wb_rf_wen;
	logic [4:0]  debug_wb_rf_wnum;
	logic [31:0] debug_wb_rf_wdata;

	logic [31:0] imem [256];
	logic [31:0] dmem [64];

	// expected writes and stores in program order
	logic [31:0] exp_pc [$];
	logic [4:0]  exp_reg [$];
	logic [31:0] exp_val [$];
	logic [31:0] exp_st_addr [$];
	logic [31:0] exp_st_data [$];

	int value_err = 0;
	int other_err = 0;
	int after_reset = 0;
	bit first_fetch_seen = 1'b0;

	// self loop in the last block
	localparam logic [31:0] loop_pc = reset_pc + 32'd1008;

	mips_core dut0 (
		.clk               (clk),
		.rst_n             (rst_n),
		.inst_sram_en      (inst_sram_en),
		.inst_sram_addr    (inst_sram_addr),
		.inst_sram_rdata   (inst_sram_rdata),
		.data_sram_en      (data_sram_en),
		.data_sram_wen     (data_sram_wen),
		.data_sram_addr    (data_sram_addr),
		.data_sram_wdata   (data_sram_wdata),
		.data_sram_rdata   (data_sram_rdata),
		.debug_wb_pc       (debug_wb_pc),
		.debug_wb_rf_wen   (debug_wb_rf_wen),
		.debug_wb_rf_wnum  (debug_wb_rf_wnum),
		.debug_wb_rf_wdata (debug_wb_rf_wdata)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] init_word(input logic [31:0] addr);
		return 32'h3c5a0000 ^ (addr * 32'h9e3779b1);
	endfunction

	function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {op_special, rs, rt, rd, shamt, fn};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// any instruction that is not a branch or jump
	function automatic logic [31:0] rand_plain();
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		int          kind;
		rs   = 5'($urandom_range(7, 0));
		rt   = 5'($urandom_range(7, 0));
		rd   = 5'($urandom_range(7, 0));
		imm  = 16'($urandom);
		kind = $urandom_range(12, 0);
		case (kind)
			0:  return r_word(fn_addu, rs, rt, rd, 5'd0);
			1:  return r_word(fn_subu, rs, rt, rd, 5'd0);
			2:  return r_word(fn_and, rs, rt, rd, 5'd0);
			3:  return r_word(fn_or, rs, rt, rd, 5'd0);
			4:  return r_word(fn_xor, rs, rt, rd, 5'd0);
			5:  return r_word(fn_slt, rs, rt, rd, 5'd0);
			6:  return r_word(fn_sll, 5'd0, rt, rd, imm[4:0]);
			7:  return i_word(op_addiu, rs, rt, imm);
			8:  return i_word(op_ori, rs, rt, imm);
			9:  return i_word(op_lui, 5'd0, rt, imm);
			10, 11: return i_word(op_lw, 5'd0, rt, {8'h0, imm[5:0], 2'b00});
			default: return i_word(op_sw, 5'd0, rt, {8'h0, imm[5:0], 2'b00});
		endcase
	endfunction

	//////////////////////////////////////////////////
	// program of 4-word blocks whose branches land on block starts

	task automatic build_program();
		int          w;
		int          dst;
		logic [31:0] target;
		logic [4:0]  rx;
		logic [5:0]  bop;
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0;
		end
		for (int r = 1; r < 8; r++) begin
			imem[r - 1] = i_word(op_addiu, 5'd0, 5'(r), 16'($urandom));
		end
		for (int blk = 2; blk < 63; blk++) begin
			w   = blk * 4;
			dst = blk + 1 + $urandom_range(3, 0);
			if (dst > 63) begin
				dst = 63;
			end
			target = reset_pc + 32'(dst * 16);
			for (int k = 0; k < 4; k++) begin
				imem[w + k] = rand_plain();
			end
			case ($urandom_range(3, 0))
				0: ;
				3: begin
					rx = 5'($urandom_range(7, 1));
					imem[w]     = i_word(op_lui, 5'd0, rx, target[31:16]);
					imem[w + 1] = i_word(op_ori, rx, rx, target[15:0]);
					imem[w + 2] = r_word(fn_jr, rx, 5'd0, 5'd0, 5'd0);
				end
				default: begin
					case ($urandom_range(3, 0))
						0: bop = op_beq;
						1: bop = op_bne;
						2: bop = op_j;
						default: bop = op_jal;
					endcase
					if (bop == op_j || bop == op_jal) begin
						imem[w + 2] = {bop, target[27:2]};
					end else begin
						imem[w + 2] = i_word(bop, 5'($urandom_range(7, 0)),
							5'($urandom_range(7, 0)), 16'(dst * 4 - (w + 3)));
					end
				end
			endcase
		end
		imem[252] = i_word(op_beq, 5'd0, 5'd0, 16'hffff);
		imem[253] = 32'h0;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want) else begin
			value_err++;
			$display("error: %s is %h, expected %h", name, got, want);
		end
	endtask

	task automatic report_and_finish();
		$display("checks done: %0d wrong values, %0d other errors", value_err, other_err);
		if (value_err != 0 || other_err != 0) begin
			$display("Done: errors found");
		end else begin
			$display("Done: no errors");
		end
		$finish;
	endtask

	`include "isa_model.svh"

	//////////////////////////////////////////////////
	// sram models with one cycle read latency

	always @(posedge clk) begin
		if (inst_sram_en) begin
			if (inst_sram_addr[31:10] == reset_pc[31:10]) begin
				inst_sram_rdata <= imem[inst_sram_addr[9:2]];
			end else begin
				inst_sram_rdata <= 32'h0;
			end
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 64; i++) begin
				dmem[i] <= init_word(32'(i * 4));
			end
		end else if (data_sram_en) begin
			if (data_sram_wen == 4'hf) begin
				dmem[data_sram_addr[7:2]] <= data_sram_wdata;
			end
			data_sram_rdata <= dmem[data_sram_addr[7:2]];
		end
	end

	//////////////////////////////////////////////////
	// output checks sampled away from the rising edge

	always @(negedge clk) begin
		if (!rst_n || after_reset == 0) begin
			check_value("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'h0);
			check_value("data_sram_en", 32'(data_sram_en), 32'h0);
			check_value("data_sram_wen", 32'(data_sram_wen), 32'h0);
		end
		if (rst_n) begin
			after_reset = after_reset + 1;
			if (inst_sram_en && !first_fetch_seen) begin
				check_value("inst_sram_addr", inst_sram_addr, reset_pc);
				first_fetch_seen = 1'b1;
			end
		end
		if (debug_wb_rf_wen) begin
			assert (debug_wb_rf_wnum != 5'd0) else begin
				other_err++;
				$display("trace entry at pc %h writes register 0", debug_wb_pc);
			end
			assert (exp_reg.size() != 0) else begin
				other_err++;
				$display("unexpected register write at pc %h", debug_wb_pc);
			end
			if (exp_reg.size() != 0) begin
				check_value("debug_wb_pc", debug_wb_pc, exp_pc.pop_front());
				check_value("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(exp_reg.pop_front()));
				check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val.pop_front());
			end
		end
		if (data_sram_wen == 4'hf) begin
			check_value("data_sram_en", 32'(data_sram_en), 32'h1);
			assert (exp_st_addr.size() != 0) else begin
				other_err++;
				$display("unexpected store to address %h", data_sram_addr);
			end
			if (exp_st_addr.size() != 0) begin
				check_value("data_sram_addr", data_sram_addr, exp_st_addr.pop_front());
				check_value("data_sram_wdata", data_sram_wdata, exp_st_data.pop_front());
			end
		end
	end

	initial begin
		int cycles;
		rst_n = 1'b0;
		void'($urandom(64));
		build_program();
		run_model(4000);
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		cycles = 0;
		while (exp_reg.size() != 0 && cycles < 20000) begin
			@(posedge clk);
			cycles++;
		end
		assert (exp_reg.size() == 0) else begin
			other_err++;
			$display("timeout: %0d register writes never reached the trace", exp_reg.size());
		end
		// idle so that stray writes or stores still show up
		cycles = 0;
		while (cycles < 64) begin
			@(posedge clk);
			cycles++;
		end
		assert (exp_st_addr.size() == 0) else begin
			other_err++;
			$display("%0d expected stores never reached the data sram", exp_st_addr.size());
		end
		report_and_finish();
	end

endmodule

`default_nettype wire

// ==== logic/mips_core.sv ====
`default_nettype none

module mips_core (
	input  logic                            clk,
	input  logic                            rst_n,
	output logic                            inst_sram_en,
	output logic [pipe_pkg::xlen-1:0]       inst_sram_addr,
	input  logic [pipe_pkg::xlen-1:0]       inst_sram_rdata,
	output logic                            data_sram_en,
	output logic [3:0]                      data_sram_wen,
	output logic [pipe_pkg::xlen-1:0]       data_sram_addr,
	output logic [pipe_pkg::xlen-1:0]       data_sram_wdata,
	input  logic [pipe_pkg::xlen-1:0]       data_sram_rdata,
	output logic [pipe_pkg::xlen-1:0]       debug_wb_pc,
	output logic                            debug_wb_rf_wen,
	output logic [pipe_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
	output logic [pipe_pkg::xlen-1:0]       debug_wb_rf_wdata
);
	import pipe_pkg::*;

	fd_if       fd ();
	redirect_if rdr ();
	dx_if       dx ();
	xm_if       xm ();
	wb_if       wb ();

	logic [xlen-1:0]       mem_fwd;
	logic [fwd_w-1:0]      fwd_a, fwd_b;
	logic [reg_addr_w-1:0] src_a, src_b;
	logic                  use_a, use_b;
	logic                  stall;

	assign rdr.stall = stall;

	fetch_stage fetch0 (
		.clk             (clk),
		.rst_n           (rst_n),
		.inst_sram_en    (inst_sram_en),
		.inst_sram_addr  (inst_sram_addr),
		.inst_sram_rdata (inst_sram_rdata),
		.redirect        (rdr),
		.fd              (fd)
	);

	decode_stage decode0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.fd       (fd),
		.redirect (rdr),
		.dx       (dx),
		.wb       (wb),
		.mem_fwd  (mem_fwd),
		.fwd_a    (fwd_a),
		.fwd_b    (fwd_b),
		.stall    (stall),
		.src_a    (src_a),
		.src_b    (src_b),
		.use_a    (use_a),
		.use_b    (use_b)
	);

	execute_stage execute0 (
		.clk             (clk),
		.rst_n           (rst_n),
		.dx              (dx),
		.xm              (xm),
		.data_sram_en    (data_sram_en),
		.data_sram_wen   (data_sram_wen),
		.data_sram_addr  (data_sram_addr),
		.data_sram_wdata (data_sram_wdata)
	);

	memory_stage memory0 (
		.clk             (clk),
		.rst_n           (rst_n),
		.xm              (xm),
		.data_sram_rdata (data_sram_rdata),
		.mem_fwd         (mem_fwd),
		.wb              (wb)
	);

	hazard_unit hazard0 (
		.src_a (src_a),
		.src_b (src_b),
		.use_a (use_a),
		.use_b (use_b),
		.dx    (dx),
		.xm    (xm),
		.wb    (wb),
		.fwd_a (fwd_a),
		.fwd_b (fwd_b),
		.stall (stall)
	);

	// trace taken straight from the writeback bundle
	assign debug_wb_pc       = wb.pc;
	assign debug_wb_rf_wen   = wb.we;
	assign debug_wb_rf_wnum  = wb.dest;
	assign debug_wb_rf_wdata = wb.data;

endmodule

`default_nettype wire

// ==== logic/hazard_unit.sv ====
`default_nettype none

module hazard_unit (
	input  logic [pipe_pkg::reg_addr_w-1:0] src_a,
	input  logic [pipe_pkg::reg_addr_w-1:0] src_b,
	input  logic                            use_a,
	input  logic                            use_b,
	dx_if.reader                            dx,
	xm_if.reader                            xm,
	wb_if.reader                            wb,
	output logic [pipe_pkg::fwd_w-1:0]      fwd_a,
	output logic [pipe_pkg::fwd_w-1:0]      fwd_b,
	output logic                            stall
);
	import pipe_pkg::*;

	// newest producer wins except loads in memory
	function automatic logic [fwd_w-1:0] fwd_sel(
		input logic [reg_addr_w-1:0] src,
		input logic [reg_addr_w-1:0] mem_dest,
		input logic                  mem_we,
		input logic                  mem_load,
		input logic [reg_addr_w-1:0] wb_dest,
		input logic                  wb_we
	);
		if (src != '0 && mem_we && !mem_load && mem_dest == src) begin
			return fwd_mem;
		end
		if (wb_we && wb_dest == src) begin
			return fwd_wb;
		end
		return fwd_reg;
	endfunction

	function automatic logic must_wait(
		input logic [reg_addr_w-1:0] src,
		input logic                  used,
		input logic [reg_addr_w-1:0] ex_dest,
		input logic                  ex_we,
		input logic [reg_addr_w-1:0] mem_dest,
		input logic                  mem_we,
		input logic                  mem_load
	);
		logic live;
		live = used && (src != '0);
		return (live && ex_we && ex_dest == src)
			|| (live && mem_we && mem_load && mem_dest == src);
	endfunction

	assign fwd_a = fwd_sel(src_a, xm.dest, xm.reg_we, xm.mem_read, wb.dest, wb.we);
	assign fwd_b = fwd_sel(src_b, xm.dest, xm.reg_we, xm.mem_read, wb.dest, wb.we);

	assign stall = must_wait(src_a, use_a, dx.dest, dx.reg_we, xm.dest, xm.reg_we, xm.mem_read)
		|| must_wait(src_b, use_b, dx.dest, dx.reg_we, xm.dest, xm.reg_we, xm.mem_read);

endmodule

`default_nettype wire

// ==== logic/memory_stage.sv ====
`default_nettype none

module memory_stage (
	input  logic                      clk,
	input  logic                      rst_n,
	xm_if.memory                      xm,
	input  logic [pipe_pkg::xlen-1:0] data_sram_rdata,
	output logic [pipe_pkg::xlen-1:0] mem_fwd,
	wb_if.driver                      wb
);
	import pipe_pkg::*;

	logic [xlen-1:0] wb_value;

	// load data arrives while the load sits here
	assign wb_value = xm.mem_read ? data_sram_rdata : xm.result;

	// only non-load results are taken from here
	assign mem_fwd = xm.result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb.we <= 1'b0;
		end else begin
			wb.we <= xm.valid & xm.reg_we & (xm.dest != '0);
		end
	end

	always_ff @(posedge clk) begin
		wb.dest <= xm.dest;
		wb.data <= wb_value;
		wb.pc   <= xm.pc;
	end

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`default_nettype none

module execute_stage (
	input  logic                      clk,
	input  logic                      rst_n,
	dx_if.execute                     dx,
	xm_if.execute                     xm,
	output logic                      data_sram_en,
	output logic [3:0]                data_sram_wen,
	output logic [pipe_pkg::xlen-1:0] data_sram_addr,
	output logic [pipe_pkg::xlen-1:0] data_sram_wdata
);
	import pipe_pkg::*;

	logic [xlen-1:0] alu_y;
	logic [xlen-1:0] result;
	logic            lt;

	assign lt = $signed(dx.src_a) < $signed(dx.src_b);

	always_comb begin
		case (dx.alu_op)
			alu_add: alu_y = dx.src_a + dx.src_b;
			alu_sub: alu_y = dx.src_a - dx.src_b;
			alu_and: alu_y = dx.src_a & dx.src_b;
			alu_or:  alu_y = dx.src_a | dx.src_b;
			alu_xor: alu_y = dx.src_a ^ dx.src_b;
			alu_slt: alu_y = {{(xlen-1){1'b0}}, lt};
			alu_sll: alu_y = dx.src_a << dx.src_b[4:0];
			alu_lui: alu_y = {dx.src_b[15:0], 16'h0};
			default: alu_y = '0;
		endcase
	end

	// jal returns past its delay slot
	assign result = dx.link ? dx.pc + 32'd8 : alu_y;

	//////////////////////////////////////////////////
	// data sram request for word accesses only
	assign data_sram_en    = dx.valid & (dx.mem_read | dx.mem_write);
	assign data_sram_wen   = {4{dx.valid & dx.mem_write}};
	assign data_sram_addr  = {alu_y[xlen-1:2], 2'b00};
	assign data_sram_wdata = dx.store_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			xm.valid    <= 1'b0;
			xm.reg_we   <= 1'b0;
			xm.mem_read <= 1'b0;
		end else begin
			xm.valid    <= dx.valid;
			xm.reg_we   <= dx.reg_we;
			xm.mem_read <= dx.mem_read;
		end
	end

	always_ff @(posedge clk) begin
		xm.result <= result;
		xm.dest   <= dx.dest;
		xm.pc     <= dx.pc;
	end

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`default_nettype none

module decode_stage (
	input  logic                            clk,
	input  logic                            rst_n,
	fd_if.decode                            fd,
	redirect_if.decode                      redirect,
	dx_if.decode                            dx,
	wb_if.reader                            wb,
	input  logic [pipe_pkg::xlen-1:0]       mem_fwd,
	input  logic [pipe_pkg::fwd_w-1:0]      fwd_a,
	input  logic [pipe_pkg::fwd_w-1:0]      fwd_b,
	input  logic                            stall,
	output logic [pipe_pkg::reg_addr_w-1:0] src_a,
	output logic [pipe_pkg::reg_addr_w-1:0] src_b,
	output logic                            use_a,
	output logic                            use_b
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [xlen-1:0] rf [32];
	logic [xlen-1:0] rf_rs, rf_rt, rs_val, rt_val;
	logic [xlen-1:0] sext, zext, pc4, br_target, j_target;
	logic [xlen-1:0] opnd_a, opnd_b;
	logic [alu_w-1:0] dec_alu_op;
	logic [reg_addr_w-1:0] dec_dest;
	logic dec_reg_we, dec_load, dec_store, dec_link;
	logic is_beq, is_bne, is_jump, is_jr, use_rs, use_rt;

	function automatic logic [xlen-1:0] pick(
		input logic [fwd_w-1:0] sel,
		input logic [xlen-1:0]  rf_val,
		input logic [xlen-1:0]  mem_val,
		input logic [xlen-1:0]  wb_val
	);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb:  return wb_val;
			default: return rf_val;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// register file with r0 reading zero

	always_ff @(posedge clk) begin
		if (wb.we) begin
			rf[wb.dest] <= wb.data;
		end
	end

	assign src_a  = fd.instr.r.rs;
	assign src_b  = fd.instr.r.rt;
	assign rf_rs  = (src_a == '0) ? '0 : rf[src_a];
	assign rf_rt  = (src_b == '0) ? '0 : rf[src_b];
	assign rs_val = pick(fwd_a, rf_rs, mem_fwd, wb.data);
	assign rt_val = pick(fwd_b, rf_rt, mem_fwd, wb.data);

	assign sext = {{16{fd.instr.i.imm[15]}}, fd.instr.i.imm};
	assign zext = {16'h0, fd.instr.i.imm};

	//////////////////////////////////////////////////
	// control decode

	always_comb begin
		dec_alu_op = alu_add;
		dec_dest   = '0;
		dec_reg_we = 1'b0;
		dec_load   = 1'b0;
		dec_store  = 1'b0;
		dec_link   = 1'b0;
		is_beq     = 1'b0;
		is_bne     = 1'b0;
		is_jump    = 1'b0;
		is_jr      = 1'b0;
		use_rs     = 1'b0;
		use_rt     = 1'b0;
		opnd_a     = rs_val;
		opnd_b     = rt_val;
		case (fd.instr.r.op)
			op_special: begin
				dec_dest   = fd.instr.r.rd;
				dec_reg_we = 1'b1;
				use_rs     = 1'b1;
				use_rt     = 1'b1;
				case (fd.instr.r.funct)
					fn_addu: dec_alu_op = alu_add;
					fn_subu: dec_alu_op = alu_sub;
					fn_and:  dec_alu_op = alu_and;
					fn_or:   dec_alu_op = alu_or;
					fn_xor:  dec_alu_op = alu_xor;
					fn_slt:  dec_alu_op = alu_slt;
					fn_sll: begin
						// shifts rt by the shamt field
						dec_alu_op = alu_sll;
						use_rs     = 1'b0;
						opnd_a     = rt_val;
						opnd_b     = {27'h0, fd.instr.r.shamt};
					end
					fn_jr: begin
						dec_reg_we = 1'b0;
						use_rt     = 1'b0;
						is_jr      = 1'b1;
					end
					default: begin
						dec_reg_we = 1'b0;
						use_rs     = 1'b0;
						use_rt     = 1'b0;
					end
				endcase
			end
			op_addiu, op_ori, op_lui, op_lw: begin
				dec_dest   = fd.instr.i.rt;
				dec_reg_we = 1'b1;
				use_rs     = (fd.instr.i.op != op_lui);
				opnd_b     = (fd.instr.i.op == op_addiu || fd.instr.i.op == op_lw) ? sext : zext;
				dec_load   = (fd.instr.i.op == op_lw);
				if (fd.instr.i.op == op_ori) begin
					dec_alu_op = alu_or;
				end else if (fd.instr.i.op == op_lui) begin
					dec_alu_op = alu_lui;
				end
			end
			op_sw: begin
				dec_store = 1'b1;
				use_rs    = 1'b1;
				use_rt    = 1'b1;
				opnd_b    = sext;
			end
			op_beq, op_bne: begin
				is_beq = (fd.instr.i.op == op_beq);
				is_bne = (fd.instr.i.op == op_bne);
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			op_j, op_jal: begin
				is_jump    = 1'b1;
				dec_link   = (fd.instr.j.op == op_jal);
				dec_reg_we = dec_link;
				dec_dest   = reg_ra;
			end
			default: ;
		endcase
	end

	assign use_a = fd.valid & use_rs;
	assign use_b = fd.valid & use_rt;

	//////////////////////////////////////////////////
	// branch compare and targets

	assign pc4       = fd.pc + 32'd4;
	assign br_target = pc4 + {sext[xlen-3:0], 2'b00};
	assign j_target  = {pc4[31:28], fd.instr.j.index, 2'b00};

	assign redirect.taken = fd.valid & ((is_beq & (rs_val == rt_val))
		| (is_bne & (rs_val != rt_val)) | is_jump | is_jr);
	assign redirect.target = is_jr ? rs_val : (is_jump ? j_target : br_target);

	// bubble on reset or stall
	always_ff @(posedge clk) begin
		if (!rst_n || stall) begin
			dx.valid     <= 1'b0;
			dx.reg_we    <= 1'b0;
			dx.mem_read  <= 1'b0;
			dx.mem_write <= 1'b0;
			dx.link      <= 1'b0;
		end else begin
			dx.valid     <= fd.valid;
			dx.reg_we    <= fd.valid & dec_reg_we;
			dx.mem_read  <= fd.valid & dec_load;
			dx.mem_write <= fd.valid & dec_store;
			dx.link      <= fd.valid & dec_link;
		end
	end

	always_ff @(posedge clk) begin
		dx.pc         <= fd.pc;
		dx.alu_op     <= dec_alu_op;
		dx.src_a      <= opnd_a;
		dx.src_b      <= opnd_b;
		dx.store_data <= rt_val;
		dx.dest       <= dec_dest;
	end

endmodule

`default_nettype wire

// ==== logic/fetch_stage.sv ====
`default_nettype none

module fetch_stage (
	input  logic                      clk,
	input  logic                      rst_n,
	output logic                      inst_sram_en,
	output logic [pipe_pkg::xlen-1:0] inst_sram_addr,
	input  logic [pipe_pkg::xlen-1:0] inst_sram_rdata,
	redirect_if.fetch                 redirect,
	fd_if.fetch                       fd
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// pc of the word on inst_sram_rdata
	logic [xlen-1:0] pc_q;
	logic            word_valid;
	logic [xlen-1:0] next_pc;

	always_comb begin
		if (redirect.stall) begin
			next_pc = pc_q;
		end else if (redirect.taken) begin
			next_pc = redirect.target;
		end else begin
			next_pc = pc_q + 32'd4;
		end
	end

	// sram keeps its word while en is low
	assign inst_sram_en   = !redirect.stall;
	assign inst_sram_addr = next_pc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q       <= reset_pc - 32'd4;
			word_valid <= 1'b0;
			fd.valid   <= 1'b0;
		end else if (!redirect.stall) begin
			pc_q       <= next_pc;
			word_valid <= 1'b1;
			fd.valid   <= word_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!redirect.stall) begin
			fd.pc    <= pc_q;
			fd.instr <= inst_sram_rdata;
		end
	end

endmodule

`default_nettype wire

// ==== logic/stage_if.sv ====
`default_nettype none

interface fd_if;
	import isa_pkg::*;
	import pipe_pkg::*;
	logic            valid;
	logic [xlen-1:0] pc;
	instr_t          instr;
	modport fetch (output valid, pc, instr);
	modport decode (input valid, pc, instr);
endinterface

interface redirect_if;
	import pipe_pkg::*;
	logic            taken;
	logic [xlen-1:0] target;
	logic            stall;
	modport decode (output taken, target);
	modport fetch (input taken, target, stall);
endinterface

interface dx_if;
	import pipe_pkg::*;
	logic                  valid;
	logic [xlen-1:0]       pc;
	logic [alu_w-1:0]      alu_op;
	logic [xlen-1:0]       src_a;
	logic [xlen-1:0]       src_b;
	logic [xlen-1:0]       store_data;
	logic [reg_addr_w-1:0] dest;
	logic                  reg_we;
	logic                  mem_read;
	logic                  mem_write;
	logic                  link;
	modport decode (output valid, pc, alu_op, src_a, src_b, store_data, dest,
		reg_we, mem_read, mem_write, link);
	modport execute (input valid, pc, alu_op, src_a, src_b, store_data, dest,
		reg_we, mem_read, mem_write, link);
	modport reader (input dest, reg_we);
endinterface

interface xm_if;
	import pipe_pkg::*;
	logic                  valid;
	logic [xlen-1:0]       result;
	logic [reg_addr_w-1:0] dest;
	logic                  reg_we;
	logic                  mem_read;
	logic [xlen-1:0]       pc;
	modport execute (output valid, result, dest, reg_we, mem_read, pc);
	modport memory (input valid, result, dest, reg_we, mem_read, pc);
	modport reader (input dest, reg_we, mem_read);
endinterface

interface wb_if;
	import pipe_pkg::*;
	logic                  we;
	logic [reg_addr_w-1:0] dest;
	logic [xlen-1:0]       data;
	logic [xlen-1:0]       pc;
	modport driver (output we, dest, data, pc);
	modport reader (input we, dest, data, pc);
endinterface

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam int alu_w      = 3;
	localparam int fwd_w      = 2;

	//////////////////////////////////////////////////
	// alu operations
	localparam logic [alu_w-1:0] alu_add = 3'd0;
	localparam logic [alu_w-1:0] alu_sub = 3'd1;
	localparam logic [alu_w-1:0] alu_and = 3'd2;
	localparam logic [alu_w-1:0] alu_or  = 3'd3;
	localparam logic [alu_w-1:0] alu_xor = 3'd4;
	localparam logic [alu_w-1:0] alu_slt = 3'd5;
	localparam logic [alu_w-1:0] alu_sll = 3'd6;
	localparam logic [alu_w-1:0] alu_lui = 3'd7;

	//////////////////////////////////////////////////
	// decode operand sources
	localparam logic [fwd_w-1:0] fwd_reg = 2'd0;
	localparam logic [fwd_w-1:0] fwd_mem = 2'd1;
	localparam logic [fwd_w-1:0] fwd_wb  = 2'd2;

endpackage

`default_nettype wire

// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	// primary opcodes
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_j       = 6'h02;
	localparam logic [5:0] op_jal     = 6'h03;
	localparam logic [5:0] op_beq     = 6'h04;
	localparam logic [5:0] op_bne     = 6'h05;
	localparam logic [5:0] op_addiu   = 6'h09;
	localparam logic [5:0] op_ori     = 6'h0d;
	localparam logic [5:0] op_lui     = 6'h0f;
	localparam logic [5:0] op_lw      = 6'h23;
	localparam logic [5:0] op_sw      = 6'h2b;

	// special function field
	localparam logic [5:0] fn_sll  = 6'h00;
	localparam logic [5:0] fn_jr   = 6'h08;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_slt  = 6'h2a;

	localparam logic [4:0]  reg_ra   = 5'd31;
	localparam logic [31:0] reset_pc = 32'hbfc00000;

	// one instruction word in three field layouts
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0]  op;
			logic [25:0] index;
		} j;
	} instr_t;

endpackage

`default_nettype wire
